/* include/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// machine address width
`define M_WIDTH 32

// renamed register specifier width
`define LG_PRF_ENTRIES 6

// branch history table index width
`define LG_PHT_SZ 10

// architectural link register for jal and bgezal
`define REG_LINK 5'd31

`endif

/* verilog/mips_decode_pkg.sv */
`include "decode_macros.svh"

package mips_decode_pkg;

	// 5-bit architectural fields are zero-extended into this
	typedef logic [`LG_PRF_ENTRIES-1:0] reg_idx_t;

	typedef enum logic [6:0] {
		NOP = 7'd0,
		II,
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		JR, JALR, MOVZ, MOVN,
		SYSCALL, BREAK, SYNC,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, MOV,
		ADDIU, MOVI, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL,
		BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
		J, JAL,
		LB, LH, LW, LBU, LHU, SB, SH, SW
	} op_t;

	// one word, three field layouts picked by opcode
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} i;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] target26;
		} j;
	} insn_t;

	typedef struct packed {
		insn_t insn;
		logic [`M_WIDTH-1:0] pc;
		logic pred; // predicted taken
		logic [`LG_PHT_SZ-1:0] pht_idx;
		logic [`M_WIDTH-1:0] pred_target;
	} fetch_t;

	typedef struct packed {
		op_t op;
		reg_idx_t src_a;
		reg_idx_t src_b;
		reg_idx_t src_c;
		reg_idx_t dst;
		logic src_a_valid;
		logic src_b_valid;
		logic src_c_valid;
		logic dst_valid;
		logic [15:0] imm;
		logic [`M_WIDTH-17:0] jmp_imm; // upper half of a jump target
		logic has_delay_slot;
		logic has_nullifying_delay_slot;
		logic br_pred;
		logic is_br;
		logic is_int;
		logic is_mem;
		logic is_store;
		logic serializing_op;
		logic fenced_op;
		logic [`M_WIDTH-1:0] pc;
		logic [`LG_PHT_SZ-1:0] pht_idx;
	} uop_t;

endpackage

/* verilog/special_decoder.sv */
`include "decode_macros.svh"

module special_decoder(
	input mips_decode_pkg::fetch_t fetch,
	output mips_decode_pkg::uop_t uop,
	output logic hit
);
	logic [5:0] funct;
	mips_decode_pkg::reg_idx_t rs;
	mips_decode_pkg::reg_idx_t rt;
	mips_decode_pkg::reg_idx_t rd;
	mips_decode_pkg::reg_idx_t shamt;
	mips_decode_pkg::op_t base_op;
	logic rd_write;

	assign funct = fetch.insn.r.funct;
	assign rs = mips_decode_pkg::reg_idx_t'(fetch.insn.r.rs);
	assign rt = mips_decode_pkg::reg_idx_t'(fetch.insn.r.rt);
	assign rd = mips_decode_pkg::reg_idx_t'(fetch.insn.r.rd);
	assign shamt = mips_decode_pkg::reg_idx_t'(fetch.insn.r.shamt);
	assign hit = (fetch.insn.r.opcode == 6'd0);

	// op named by the function field alone
	always_comb
	begin
		case (funct)
			6'd0: base_op = mips_decode_pkg::SLL;
			6'd2: base_op = mips_decode_pkg::SRL;
			6'd3: base_op = mips_decode_pkg::SRA;
			6'd4: base_op = mips_decode_pkg::SLLV;
			6'd6: base_op = mips_decode_pkg::SRLV;
			6'd7: base_op = mips_decode_pkg::SRAV;
			6'd8: base_op = mips_decode_pkg::JR;
			6'd9: base_op = mips_decode_pkg::JALR;
			6'd10: base_op = mips_decode_pkg::MOVZ;
			6'd11: base_op = mips_decode_pkg::MOVN;
			6'd12: base_op = mips_decode_pkg::SYSCALL;
			6'd13: base_op = mips_decode_pkg::BREAK;
			6'd15: base_op = mips_decode_pkg::SYNC;
			6'd33: base_op = mips_decode_pkg::ADDU;
			6'd35: base_op = mips_decode_pkg::SUBU;
			6'd36: base_op = mips_decode_pkg::AND;
			6'd37: base_op = mips_decode_pkg::OR;
			6'd38: base_op = mips_decode_pkg::XOR;
			6'd39: base_op = mips_decode_pkg::NOR;
			6'd42: base_op = mips_decode_pkg::SLT;
			6'd43: base_op = mips_decode_pkg::SLTU;
			6'd52: base_op = mips_decode_pkg::NOP; // teq, traps not modelled
			default: base_op = mips_decode_pkg::II;
		endcase
	end

	always_comb
	begin
		uop = '0;
		uop.op = mips_decode_pkg::II;
		uop.pc = fetch.pc;
		uop.pht_idx = fetch.pht_idx;
		rd_write = 1'b0;
		if (hit && (base_op != mips_decode_pkg::II))
		begin
			uop.op = base_op;
			uop.is_int = 1'b1;
			case (funct)
				6'd0, 6'd2, 6'd3:
				begin
					uop.src_a = rt;
					uop.src_a_valid = 1'b1;
					uop.src_b = shamt; // amount rides in src_b, no read
					rd_write = 1'b1;
				end
				6'd8, 6'd9:
				begin
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					uop.dst = rd;
					uop.dst_valid = (funct == 6'd9) && (rd != '0);
					uop.has_delay_slot = 1'b1;
					uop.is_br = 1'b1;
					// predicted target travels with the uop for the check
					uop.imm = fetch.pred_target[15:0];
					uop.jmp_imm = fetch.pred_target[`M_WIDTH-1:16];
				end
				6'd12: uop.fenced_op = 1'b1;
				6'd13: uop.serializing_op = 1'b1;
				6'd15: uop.is_mem = 1'b1; // sync orders memory
				6'd35:
				begin
					uop.src_a = rs; // subu keeps operand order
					uop.src_a_valid = 1'b1;
					uop.src_b = rt;
					uop.src_b_valid = 1'b1;
					rd_write = 1'b1;
				end
				6'd52: ;
				default:
				begin
					uop.src_a = rt;
					uop.src_a_valid = 1'b1;
					uop.src_b = rs;
					uop.src_b_valid = 1'b1;
					uop.src_c = rd; // old rd for conditional moves
					uop.src_c_valid = (funct == 6'd10) || (funct == 6'd11);
					rd_write = 1'b1;
				end
			endcase
			if ((funct == 6'd37) && (rs == '0))
			begin
				uop.op = mips_decode_pkg::MOV; // or with $zero copies rt
				uop.src_b_valid = 1'b0;
			end
			if (rd_write)
			begin
				uop.dst = rd;
				uop.dst_valid = (rd != '0);
				if (rd == '0)
					uop.op = mips_decode_pkg::NOP; // also the all-zero word
			end
		end
	end

	always_comb
	begin
		if (uop.dst_valid)
			assert (uop.dst != '0) else $error("special: write to register zero");
	end

endmodule

/* verilog/branch_decoder.sv */
`include "decode_macros.svh"

module branch_decoder(
	input mips_decode_pkg::fetch_t fetch,
	output mips_decode_pkg::uop_t uop,
	output logic hit
);
	logic [5:0] opcode;
	logic [4:0] rt_field;
	mips_decode_pkg::reg_idx_t rs;
	mips_decode_pkg::reg_idx_t rt;
	logic regimm;
	logic known;
	logic likely;

	assign opcode = fetch.insn.i.opcode;
	assign rt_field = fetch.insn.i.rt;
	assign rs = mips_decode_pkg::reg_idx_t'(fetch.insn.i.rs);
	assign rt = mips_decode_pkg::reg_idx_t'(rt_field);
	assign regimm = (opcode == 6'd1);
	assign hit = opcode inside {[6'd1:6'd7], [6'd20:6'd23]};
	assign known = !regimm || (rt_field inside {5'd0, 5'd1, 5'd2, 5'd3, 5'd17});
	assign likely = (opcode inside {[6'd20:6'd23]}) || (regimm && (rt_field inside {5'd2, 5'd3}));

	always_comb
	begin
		uop = '0;
		uop.op = mips_decode_pkg::II;
		uop.pc = fetch.pc;
		uop.pht_idx = fetch.pht_idx;
		if (hit && known)
		begin
			uop.is_br = 1'b1;
			uop.is_int = 1'b1;
			uop.has_delay_slot = 1'b1;
			uop.has_nullifying_delay_slot = likely;
			uop.br_pred = fetch.pred;
			case (opcode)
				6'd1:
				begin
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					uop.imm = fetch.insn.i.imm16;
					case (rt_field)
						5'd0: uop.op = mips_decode_pkg::BLTZ;
						5'd1: uop.op = mips_decode_pkg::BGEZ;
						5'd2: uop.op = mips_decode_pkg::BLTZL;
						5'd3: uop.op = mips_decode_pkg::BGEZL;
						default:
						begin
							// links whether taken or not
							uop.dst = mips_decode_pkg::reg_idx_t'(`REG_LINK);
							uop.dst_valid = 1'b1;
							uop.src_a_valid = (rs != '0);
							if (rs == '0)
								uop.op = mips_decode_pkg::BAL;
							else
								uop.op = mips_decode_pkg::BGEZAL;
						end
					endcase
				end
				6'd2: uop.op = mips_decode_pkg::J; // target folded at fetch
				6'd3:
				begin
					uop.op = mips_decode_pkg::JAL;
					uop.dst = mips_decode_pkg::reg_idx_t'(`REG_LINK);
					uop.dst_valid = 1'b1;
					uop.br_pred = 1'b1;
					uop.imm = fetch.insn.j.target26[15:0];
					uop.jmp_imm = {{(`M_WIDTH-26){1'b0}}, fetch.insn.j.target26[25:16]};
				end
				default:
				begin
					uop.src_a = rs;
					uop.src_a_valid = 1'b1;
					uop.src_b = rt;
					uop.src_b_valid = !opcode[1]; // beq/bne forms also read rt
					uop.imm = fetch.insn.i.imm16;
					case (opcode)
						6'd4: uop.op = mips_decode_pkg::BEQ;
						6'd5: uop.op = mips_decode_pkg::BNE;
						6'd6: uop.op = mips_decode_pkg::BLEZ;
						6'd7: uop.op = mips_decode_pkg::BGTZ;
						6'd20: uop.op = mips_decode_pkg::BEQL;
						6'd21: uop.op = mips_decode_pkg::BNEL;
						6'd22: uop.op = mips_decode_pkg::BLEZL;
						default: uop.op = mips_decode_pkg::BGTZL;
					endcase
				end
			endcase
		end
	end

	always_comb
	begin
		if (uop.has_nullifying_delay_slot)
			assert (uop.has_delay_slot) else $error("branch: nullify without delay slot");
	end

endmodule

/* verilog/alu_imm_decoder.sv */
module alu_imm_decoder(
	input mips_decode_pkg::fetch_t fetch,
	output mips_decode_pkg::uop_t uop,
	output logic hit
);
	logic [5:0] opcode;
	mips_decode_pkg::reg_idx_t rs;
	mips_decode_pkg::reg_idx_t rt;

	assign opcode = fetch.insn.i.opcode;
	assign rs = mips_decode_pkg::reg_idx_t'(fetch.insn.i.rs);
	assign rt = mips_decode_pkg::reg_idx_t'(fetch.insn.i.rt);
	assign hit = opcode inside {[6'd9:6'd15]};

	always_comb
	begin
		uop = '0;
		uop.op = mips_decode_pkg::II;
		uop.pc = fetch.pc;
		uop.pht_idx = fetch.pht_idx;
		if (hit)
		begin
			uop.is_int = 1'b1;
			uop.imm = fetch.insn.i.imm16;
			uop.src_a = rs;
			uop.src_a_valid = 1'b1;
			uop.dst = rt; // rt is the target in I format
			uop.dst_valid = (rt != '0);
			case (opcode)
				6'd9:
				begin
					if (rs == '0)
					begin
						uop.op = mips_decode_pkg::MOVI; // li idiom
						uop.src_a_valid = 1'b0;
					end
					else
						uop.op = mips_decode_pkg::ADDIU;
				end
				6'd10: uop.op = mips_decode_pkg::SLTI;
				6'd11: uop.op = mips_decode_pkg::SLTIU;
				6'd12: uop.op = mips_decode_pkg::ANDI;
				6'd13: uop.op = mips_decode_pkg::ORI;
				6'd14: uop.op = mips_decode_pkg::XORI;
				default:
				begin
					uop.op = mips_decode_pkg::LUI;
					uop.src_a_valid = 1'b0; // immediate only
				end
			endcase
			if (rt == '0)
				uop.op = mips_decode_pkg::NOP; // result discarded
		end
	end

endmodule

/* verilog/mem_decoder.sv */
module mem_decoder(
	input mips_decode_pkg::fetch_t fetch,
	output mips_decode_pkg::uop_t uop,
	output logic hit
);
	logic [5:0] opcode;
	mips_decode_pkg::reg_idx_t rs;
	mips_decode_pkg::reg_idx_t rt;
	logic store;

	assign opcode = fetch.insn.i.opcode;
	assign rs = mips_decode_pkg::reg_idx_t'(fetch.insn.i.rs);
	assign rt = mips_decode_pkg::reg_idx_t'(fetch.insn.i.rt);
	assign hit = opcode inside {6'd32, 6'd33, 6'd35, 6'd36, 6'd37, 6'd40, 6'd41, 6'd43,
		6'd48, 6'd51};
	assign store = opcode[3]; // sb sh sw

	always_comb
	begin
		uop = '0;
		uop.op = mips_decode_pkg::II;
		uop.pc = fetch.pc;
		uop.pht_idx = fetch.pht_idx;
		if (hit)
		begin
			if (opcode == 6'd51)
			begin
				uop.op = mips_decode_pkg::NOP; // pref is only a hint
				uop.is_int = 1'b1;
			end
			else
			begin
				uop.src_a = rs; // base
				uop.src_a_valid = 1'b1;
				uop.imm = fetch.insn.i.imm16;
				uop.is_mem = 1'b1;
				uop.is_store = store;
				if (store)
				begin
					uop.src_b = rt; // store data
					uop.src_b_valid = 1'b1;
				end
				else
				begin
					uop.dst = rt;
					uop.dst_valid = (rt != '0);
				end
				case (opcode)
					6'd32: uop.op = mips_decode_pkg::LB;
					6'd33: uop.op = mips_decode_pkg::LH;
					6'd36: uop.op = mips_decode_pkg::LBU;
					6'd37: uop.op = mips_decode_pkg::LHU;
					6'd40: uop.op = mips_decode_pkg::SB;
					6'd41: uop.op = mips_decode_pkg::SH;
					6'd43: uop.op = mips_decode_pkg::SW;
					default: uop.op = mips_decode_pkg::LW; // lw, and ll without a link
				endcase
			end
		end
	end

	always_comb
	begin
		if (uop.is_store)
			assert (uop.is_mem) else $error("mem: store not marked as memory op");
	end

endmodule

/* verilog/uop_latch.sv */
module uop_latch(
	input logic clk,
	input logic arst_n,
	input logic insn_valid,
	input logic [3:0] hits, // special, branch, imm, mem
	input mips_decode_pkg::uop_t special_uop,
	input mips_decode_pkg::uop_t branch_uop,
	input mips_decode_pkg::uop_t imm_uop,
	input mips_decode_pkg::uop_t mem_uop,
	output logic uop_valid,
	output mips_decode_pkg::uop_t uop
);
	mips_decode_pkg::uop_t sel;

	always_comb
	begin
		// nobody claimed the opcode
		sel = '0;
		sel.op = mips_decode_pkg::II;
		sel.pc = special_uop.pc;
		sel.pht_idx = special_uop.pht_idx;
		case (hits)
			4'b0001: sel = special_uop;
			4'b0010: sel = branch_uop;
			4'b0100: sel = imm_uop;
			4'b1000: sel = mem_uop;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			uop_valid <= 1'b0;
			uop <= '0;
		end
		else
		begin
			uop_valid <= insn_valid;
			if (insn_valid)
				uop <= sel; // hold on idle cycles
		end
	end

	// decoders own disjoint opcode ranges
	a_hits_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
		insn_valid |-> $onehot0(hits));

endmodule

/* verilog/mips_decode_top.sv */
module mips_decode_top(
	input logic clk,
	input logic arst_n,
	input logic insn_valid,
	input mips_decode_pkg::fetch_t fetch,
	output logic uop_valid,
	output mips_decode_pkg::uop_t uop
);
	mips_decode_pkg::uop_t special_uop;
	mips_decode_pkg::uop_t branch_uop;
	mips_decode_pkg::uop_t imm_uop;
	mips_decode_pkg::uop_t mem_uop;
	logic [3:0] hits;

	special_decoder u_special (
		.fetch(fetch),
		.uop(special_uop),
		.hit(hits[0])
	);

	branch_decoder u_branch (
		.fetch(fetch),
		.uop(branch_uop),
		.hit(hits[1])
	);

	alu_imm_decoder u_alu_imm (
		.fetch(fetch),
		.uop(imm_uop),
		.hit(hits[2])
	);

	mem_decoder u_mem (
		.fetch(fetch),
		.uop(mem_uop),
		.hit(hits[3])
	);

	// one-cycle decode register
	uop_latch u_latch (
		.clk(clk),
		.arst_n(arst_n),
		.insn_valid(insn_valid),
		.hits(hits),
		.special_uop(special_uop),
		.branch_uop(branch_uop),
		.imm_uop(imm_uop),
		.mem_uop(mem_uop),
		.uop_valid(uop_valid),
		.uop(uop)
	);

endmodule

/* include/decode_vectors.svh */
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: word, pred, pred_target, op, dst, imm, flags
// flags: dst_valid src_a_valid src_b_valid is_br br_pred nullify is_mem is_store fenced serial

typedef struct packed {
	logic dst_valid;
	logic src_a_valid;
	logic src_b_valid;
	logic is_br;
	logic br_pred;
	logic nullify; // likely branch
	logic is_mem;
	logic is_store;
	logic fenced;
	logic serializing;
} flags_t;

typedef struct packed {
	logic [31:0] word;
	logic pred;
	logic [31:0] pred_target;
	mips_decode_pkg::op_t op;
	logic [5:0] dst;
	logic [15:0] imm;
	flags_t flags;
} vec_t;

localparam int NUM_VECS = 33;

localparam vec_t VECS [NUM_VECS] = '{
	// special, function field
	'{32'h00221821, 1'b0, 32'h0, mips_decode_pkg::ADDU, 6'd3, 16'h0000, 10'b1110000000},
	'{32'h000520C0, 1'b0, 32'h0, mips_decode_pkg::SLL, 6'd4, 16'h0000, 10'b1100000000},
	'{32'h01073007, 1'b0, 32'h0, mips_decode_pkg::SRAV, 6'd6, 16'h0000, 10'b1110000000},
	'{32'h014B480B, 1'b0, 32'h0, mips_decode_pkg::MOVN, 6'd9, 16'h0000, 10'b1110000000},
	'{32'h00220021, 1'b0, 32'h0, mips_decode_pkg::NOP, 6'd0, 16'h0000, 10'b0110000000},
	'{32'h00000000, 1'b0, 32'h0, mips_decode_pkg::NOP, 6'd0, 16'h0000, 10'b0100000000},
	'{32'h000D6025, 1'b0, 32'h0, mips_decode_pkg::MOV, 6'd12, 16'h0000, 10'b1100000000},
	'{32'h0000000C, 1'b0, 32'h0, mips_decode_pkg::SYSCALL, 6'd0, 16'h0000, 10'b0000000010},
	'{32'h0000000D, 1'b0, 32'h0, mips_decode_pkg::BREAK, 6'd0, 16'h0000, 10'b0000000001},
	'{32'h00000001, 1'b0, 32'h0, mips_decode_pkg::II, 6'd0, 16'h0000, 10'b0000000000},
	'{32'h03E00008, 1'b0, 32'h00401234, mips_decode_pkg::JR, 6'd0, 16'h1234, 10'b0101000000},
	'{32'h00000034, 1'b0, 32'h0, mips_decode_pkg::NOP, 6'd0, 16'h0000, 10'b0000000000},
	// immediate alu
	'{32'h24850010, 1'b0, 32'h0, mips_decode_pkg::ADDIU, 6'd5, 16'h0010, 10'b1100000000},
	'{32'h28E6FFFF, 1'b0, 32'h0, mips_decode_pkg::SLTI, 6'd6, 16'hFFFF, 10'b1100000000},
	'{32'h312800FF, 1'b0, 32'h0, mips_decode_pkg::ANDI, 6'd8, 16'h00FF, 10'b1100000000},
	'{32'h3C0A1234, 1'b0, 32'h0, mips_decode_pkg::LUI, 6'd10, 16'h1234, 10'b1000000000},
	'{32'h24020042, 1'b0, 32'h0, mips_decode_pkg::MOVI, 6'd2, 16'h0042, 10'b1000000000},
	'{32'h34600005, 1'b0, 32'h0, mips_decode_pkg::NOP, 6'd0, 16'h0005, 10'b0100000000},
	// branches and jumps
	'{32'h10220004, 1'b1, 32'h0, mips_decode_pkg::BEQ, 6'd0, 16'h0004, 10'b0111100000},
	'{32'h5064FFFE, 1'b0, 32'h0, mips_decode_pkg::BEQL, 6'd0, 16'hFFFE, 10'b0111010000},
	'{32'h04A20010, 1'b1, 32'h0, mips_decode_pkg::BLTZL, 6'd0, 16'h0010, 10'b0101110000},
	'{32'h04110020, 1'b1, 32'h0, mips_decode_pkg::BAL, 6'd31, 16'h0020, 10'b1001100000},
	'{32'h1CC00008, 1'b0, 32'h0, mips_decode_pkg::BGTZ, 6'd0, 16'h0008, 10'b0101000000},
	'{32'h0C100040, 1'b0, 32'h0, mips_decode_pkg::JAL, 6'd31, 16'h0040, 10'b1001100000},
	'{32'h04050000, 1'b0, 32'h0, mips_decode_pkg::II, 6'd0, 16'h0000, 10'b0000000000},
	// loads, stores, pref, unused opcode
	'{32'h8FA80004, 1'b0, 32'h0, mips_decode_pkg::LW, 6'd8, 16'h0004, 10'b1100001000},
	'{32'h90400000, 1'b0, 32'h0, mips_decode_pkg::LBU, 6'd0, 16'h0000, 10'b0100001000},
	'{32'hAFA90008, 1'b0, 32'h0, mips_decode_pkg::SW, 6'd0, 16'h0008, 10'b0110001100},
	'{32'hA041FFFC, 1'b0, 32'h0, mips_decode_pkg::SB, 6'd0, 16'hFFFC, 10'b0110001100},
	'{32'hC0870000, 1'b0, 32'h0, mips_decode_pkg::LW, 6'd7, 16'h0000, 10'b1100001000},
	'{32'hCC800000, 1'b0, 32'h0, mips_decode_pkg::NOP, 6'd0, 16'h0000, 10'b0000000000},
	'{32'h40000000, 1'b0, 32'h0, mips_decode_pkg::II, 6'd0, 16'h0000, 10'b0000000000},
	'{32'h84A30002, 1'b0, 32'h0, mips_decode_pkg::LH, 6'd3, 16'h0002, 10'b1100001000}
};

`endif

/* sim/tb_decode.sv */
`include "decode_macros.svh"

module tb_decode;
	`include "decode_vectors.svh"

	logic clk;
	logic arst_n;
	logic insn_valid;
	mips_decode_pkg::fetch_t fetch;
	logic uop_valid;
	mips_decode_pkg::uop_t uop;

	logic [31:0] lcg_state;
	mips_decode_pkg::uop_t held; // value seen at the previous falling edge
	logic exp_valid; // a vector went in before the last rising edge
	int exp_idx;
	logic [`M_WIDTH-1:0] exp_pc;
	logic [`LG_PHT_SZ-1:0] exp_pht;

	mips_decode_top UUT (
		.clk(clk),
		.arst_n(arst_n),
		.insn_valid(insn_valid),
		.fetch(fetch),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset plus at most three cycles per vector
	initial
	begin
		#((16 + 3 * NUM_VECS) * 100);
		$display("timeout: the decode stage did not get through the vector table in time");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else
		begin
			$display("ERR %0t: %s", $time, msg);
			$display("Simulation FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic drive_idle;
		lcg_state = lcg_next(lcg_state);
		insn_valid = 1'b0;
		fetch.insn = lcg_state; // junk, must not reach uop
		fetch.pc = ~lcg_state;
		fetch.pred = lcg_state[7];
		fetch.pht_idx = lcg_state[25:16];
		fetch.pred_target = {lcg_state[15:0], lcg_state[31:16]};
		exp_valid = 1'b0;
	endtask

	task automatic drive_vector(input int i);
		lcg_state = lcg_next(lcg_state);
		insn_valid = 1'b1;
		fetch.insn = VECS[i].word;
		fetch.pred = VECS[i].pred;
		fetch.pred_target = VECS[i].pred_target;
		fetch.pc = {lcg_state[31:2], 2'b00};
		lcg_state = lcg_next(lcg_state);
		fetch.pht_idx = lcg_state[25:16];
		exp_valid = 1'b1;
		exp_idx = i;
		exp_pc = fetch.pc;
		exp_pht = fetch.pht_idx;
	endtask

	task automatic check_uop(input int i);
		vec_t v;
		string tag;
		logic movc;
		v = VECS[i];
		tag = $sformatf("vector %0d (%h)", i, v.word);
		movc = (v.op == mips_decode_pkg::MOVZ) || (v.op == mips_decode_pkg::MOVN);
		check(uop.op == v.op, $sformatf("%s op %0d, expected %0d", tag, uop.op, v.op));
		check(uop.dst == v.dst, $sformatf("%s dst %0d, expected %0d", tag, uop.dst, v.dst));
		check(uop.imm == v.imm, $sformatf("%s imm %h, expected %h", tag, uop.imm, v.imm));
		check(uop.dst_valid == v.flags.dst_valid, {tag, " dst_valid wrong"});
		check(uop.src_a_valid == v.flags.src_a_valid, {tag, " src_a_valid wrong"});
		check(uop.src_b_valid == v.flags.src_b_valid, {tag, " src_b_valid wrong"});
		check(uop.src_c_valid == movc, {tag, " src_c_valid wrong"}); // conditional moves only
		check(uop.is_br == v.flags.is_br, {tag, " is_br wrong"});
		check(uop.has_delay_slot == v.flags.is_br, {tag, " delay slot wrong"});
		check(uop.br_pred == v.flags.br_pred, {tag, " br_pred wrong"});
		check(uop.has_nullifying_delay_slot == v.flags.nullify, {tag, " nullify wrong"});
		check(uop.is_mem == v.flags.is_mem, {tag, " is_mem wrong"});
		check(uop.is_store == v.flags.is_store, {tag, " is_store wrong"});
		check(uop.fenced_op == v.flags.fenced, {tag, " fenced_op wrong"});
		check(uop.serializing_op == v.flags.serializing, {tag, " serializing_op wrong"});
		check(uop.pc == exp_pc, $sformatf("%s pc %h, expected %h", tag, uop.pc, exp_pc));
		check(uop.pht_idx == exp_pht,
			$sformatf("%s pht_idx %h, expected %h", tag, uop.pht_idx, exp_pht));
	endtask

	// outputs at a falling edge belong to the inputs of the edge before
	task automatic next_cycle;
		@(negedge clk);
		if (exp_valid)
		begin
			check(uop_valid === 1'b1,
				$sformatf("vector %0d gave no uop_valid one cycle later", exp_idx));
			check_uop(exp_idx);
		end
		else
		begin
			check(uop_valid === 1'b0, "uop_valid high without an instruction");
			check(uop === held, "uop changed while uop_valid was low");
		end
		held = uop;
	endtask

	initial
	begin
		arst_n = 1'b0;
		insn_valid = 1'b0;
		fetch = '0;
		lcg_state = 32'd21477;
		held = '0;
		exp_valid = 1'b0;
		exp_idx = 0;
		exp_pc = '0;
		exp_pht = '0;
		repeat (16)
		begin
			@(negedge clk);
			check(uop_valid === 1'b0 && uop === '0, "uop not cleared while arst_n is low");
		end
		arst_n = 1'b1;
		drive_idle();
		next_cycle(); // first edge out of reset
		for (int i = 0; i < NUM_VECS; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			if (lcg_state[20])
			begin
				drive_idle(); // gap before this vector
				next_cycle();
			end
			drive_vector(i);
			next_cycle();
		end
		drive_idle();
		next_cycle();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+include
verilog/mips_decode_pkg.sv
verilog/special_decoder.sv
verilog/branch_decoder.sv
verilog/alu_imm_decoder.sv
verilog/mem_decoder.sv
verilog/uop_latch.sv
verilog/mips_decode_top.sv
sim/tb_decode.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_decode || exit 1
out=$(./obj_dir/Vtb_decode 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
